//--- isa_pkg.sv
package isa_pkg;

    typedef logic [8:0] instr_t; // one program word

    typedef enum logic [1:0] {
        ITYPE_ALU    = 2'b00, // rd = rd op rs
        ITYPE_BRANCH = 2'b01, // pc relative when r0 != 0
        ITYPE_IMM    = 2'b10, // r1 = r0 + imm
        ITYPE_MEM    = 2'b11  // load or store, bit 6 picks
    } itype_t;

    typedef enum logic [2:0] {
        ALU_AND = 3'd0,
        ALU_ADD = 3'd1,
        ALU_SUB = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SHL = 3'd5, // shift by rs[2:0]
        ALU_SHR = 3'd6, // logical, zero fill
        ALU_MOV = 3'd7  // rd = rs
    } alu_op_t;

    // field positions inside instr_t
    localparam int TYPE_LSB  = 7; // type sits in [8:7]
    localparam int OP_LSB    = 4; // alu op in [6:4]
    localparam int ST_BIT    = 6; // store when set
    localparam int MREG_LSB  = 4; // load/store data reg in [5:4]
    localparam int RD_LSB    = 2; // alu rd, also mem address reg
    localparam int RS_LSB    = 0; // alu rs
    localparam int IMM_W     = 7; // branch offset and immediate width

    localparam instr_t INSTR_DONE = 9'b010000000; // checked before the type field

endpackage

//--- core_pkg.sv
package core_pkg;

    typedef logic [7:0] word_t;    // data word, wraps at 8 bits
    typedef logic [1:0] reg_idx_t; // r0..r3

    // one register write as seen on the trace port
    typedef struct packed {
        reg_idx_t dest; // register written
        word_t    data; // value written
    } wb_rec_t;

    // one store as seen on the trace port
    typedef struct packed {
        word_t addr; // data memory address
        word_t data; // stored value
    } st_rec_t;

endpackage

//--- ram_array.sv
`timescale 1ns/1ns

module ram_array #(
    parameter type word_type = logic [7:0],
    parameter int DEPTH = 16,
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
    input  logic          clk,
    input  logic          we,    // write strobe
    input  logic [AW-1:0] waddr,
    input  word_type      wdata,
    input  logic [AW-1:0] raddr,
    output word_type      rdata  // async read
);

    word_type mem [DEPTH]; // storage, no reset

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata; // written at the edge
        end
    end

    assign rdata = mem[raddr]; // combinational read

endmodule

//--- core_if.sv
`timescale 1ns/1ns

// decoded control from the decoder into the execute stage
interface ctrl_if;
    logic               branch_en;     // branch on r0 != 0
    logic               write_en;      // register write this cycle
    logic               mem_read;      // load
    logic               mem_write;     // store
    logic               use_immediate; // r1 = r0 + imm
    isa_pkg::alu_op_t   alu_op;
    core_pkg::reg_idx_t rd;            // destination, or store data reg
    core_pkg::reg_idx_t rs;            // second operand
    core_pkg::reg_idx_t addr_reg;      // load/store address reg
    logic [6:0]         imm;           // raw 7 bit field

    modport dec (output branch_en, write_en, mem_read, mem_write, use_immediate,
                 output alu_op, rd, rs, addr_reg, imm);
    modport exe (input branch_en, write_en, mem_read, mem_write, use_immediate,
                 input alu_op, rd, rs, addr_reg, imm);
endinterface

// core side of the data memory
interface mem_if;
    logic            we;    // store strobe
    core_pkg::word_t addr;
    core_pkg::word_t wdata;
    core_pkg::word_t rdata; // follows addr

    modport exe (output we, addr, wdata, input rdata);
    modport mem (input we, addr, wdata, output rdata);
endinterface

//--- fetch_unit.sv
`timescale 1ns/1ns

module fetch_unit #(
    parameter int PROG_DEPTH = 128,
    localparam int PW = (PROG_DEPTH > 1) ? $clog2(PROG_DEPTH) : 1
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            prog_we,    // host program write
    input  logic [PW-1:0]   prog_addr,
    input  isa_pkg::instr_t prog_data,
    input  logic            start,      // host start pulse
    input  logic            done,       // done word decoded
    input  logic            redirect,   // taken branch
    input  logic [PW-1:0]   target,
    output logic            launch,     // start accepted this edge
    output logic            busy,
    output logic            done_pulse, // one cycle after the done edge
    output logic [PW-1:0]   pc,
    output isa_pkg::instr_t instr
);

    logic [PW-1:0] pc_next; // sequential pc with wrap

    assign launch  = start && !busy; // start while running is dropped
    assign pc_next = (pc == PW'(PROG_DEPTH - 1)) ? '0 : pc + PW'(1);

    ram_array #(
        .word_type (isa_pkg::instr_t),
        .DEPTH     (PROG_DEPTH)
    ) i_prog_mem (
        .clk   (clk),
        .we    (prog_we && !busy), // host loads only while idle
        .waddr (prog_addr),
        .wdata (prog_data),
        .raddr (pc),
        .rdata (instr)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            busy       <= 1'b0;
            done_pulse <= 1'b0;
            pc         <= '0;
        end else begin
            done_pulse <= 1'b0; // default low
            if (launch) begin
                busy <= 1'b1;
                pc   <= '0; // always run from address 0
            end else if (busy) begin
                if (done) begin
                    busy       <= 1'b0; // done retires, nothing else
                    done_pulse <= 1'b1;
                end else if (redirect) begin
                    pc <= target;
                end else begin
                    pc <= pc_next;
                end
            end
        end
    end

endmodule

//--- control_decoder.sv
`timescale 1ns/1ns

module control_decoder (
    input  isa_pkg::instr_t instr,
    input  logic            valid, // core busy
    output logic            done,  // done word seen
    ctrl_if.dec             ctrl
);

    isa_pkg::itype_t i_type; // bits 8..7
    logic            r_w;    // bit 6, store when set

    assign i_type = isa_pkg::itype_t'(instr[isa_pkg::TYPE_LSB +: 2]);
    assign r_w    = instr[isa_pkg::ST_BIT];

    always_comb begin
        // defaults: nothing happens
        done               = 1'b0;
        ctrl.branch_en     = 1'b0;
        ctrl.write_en      = 1'b0;
        ctrl.mem_read      = 1'b0;
        ctrl.mem_write     = 1'b0;
        ctrl.use_immediate = 1'b0;
        // field extraction, overridden per type below
        ctrl.alu_op   = isa_pkg::alu_op_t'(instr[isa_pkg::OP_LSB +: 3]);
        ctrl.rd       = instr[isa_pkg::RD_LSB +: 2];
        ctrl.rs       = instr[isa_pkg::RS_LSB +: 2];
        ctrl.addr_reg = instr[isa_pkg::RD_LSB +: 2]; // mem address reg shares rd bits
        ctrl.imm      = instr[isa_pkg::IMM_W-1:0];

        if (valid) begin
            if (instr == isa_pkg::INSTR_DONE) begin
                done = 1'b1; // wins over the branch decode
            end else begin
                case (i_type)
                    isa_pkg::ITYPE_ALU: begin
                        ctrl.write_en = 1'b1; // rd = rd op rs
                    end
                    isa_pkg::ITYPE_BRANCH: begin
                        ctrl.branch_en = 1'b1; // taken only if r0 != 0
                    end
                    isa_pkg::ITYPE_IMM: begin
                        ctrl.write_en      = 1'b1;
                        ctrl.use_immediate = 1'b1;
                        ctrl.rd            = 2'd1; // always r1
                        ctrl.rs            = 2'd0; // base is r0
                    end
                    default: begin // load/store
                        ctrl.rd = instr[isa_pkg::MREG_LSB +: 2]; // data reg
                        if (r_w) begin
                            ctrl.mem_write = 1'b1;
                        end else begin
                            ctrl.mem_read = 1'b1;
                            ctrl.write_en = 1'b1; // load writes the data reg
                        end
                    end
                endcase
            end
        end
    end

endmodule

//--- execute_unit.sv
`timescale 1ns/1ns

module execute_unit #(
    parameter int PROG_DEPTH = 128,
    localparam int PW = (PROG_DEPTH > 1) ? $clog2(PROG_DEPTH) : 1
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              launch,   // clears the register file
    input  logic [PW-1:0]     pc,
    ctrl_if.exe               ctrl,
    mem_if.exe                mem,
    output logic              redirect, // taken branch
    output logic [PW-1:0]     target,
    output logic              wb_valid,
    output core_pkg::wb_rec_t wb_rec,
    output logic              st_valid,
    output core_pkg::st_rec_t st_rec
);

    core_pkg::word_t regs [4]; // r0..r3
    core_pkg::word_t op_a;     // regs[rd]
    core_pkg::word_t op_b;     // regs[rs]
    core_pkg::word_t imm_ext;  // sign extended immediate
    core_pkg::word_t alu_res;
    core_pkg::word_t result;   // value for the register write
    int              br_sum;   // pc + offset before wrap

    assign op_a    = regs[ctrl.rd];
    assign op_b    = regs[ctrl.rs];
    assign imm_ext = {ctrl.imm[6], ctrl.imm};

    always_comb begin
        case (ctrl.alu_op)
            isa_pkg::ALU_AND: alu_res = op_a & op_b;
            isa_pkg::ALU_ADD: alu_res = op_a + op_b;
            isa_pkg::ALU_SUB: alu_res = op_a - op_b;
            isa_pkg::ALU_OR:  alu_res = op_a | op_b;
            isa_pkg::ALU_XOR: alu_res = op_a ^ op_b;
            isa_pkg::ALU_SHL: alu_res = op_a << op_b[2:0]; // low three bits only
            isa_pkg::ALU_SHR: alu_res = op_a >> op_b[2:0];
            default:          alu_res = op_b; // move
        endcase
    end

    always_comb begin
        if (ctrl.mem_read) begin
            result = mem.rdata; // load
        end else if (ctrl.use_immediate) begin
            result = op_b + imm_ext; // op_b is r0 here
        end else begin
            result = alu_res;
        end
    end

    // branch target, wraps at PROG_DEPTH
    always_comb begin
        br_sum = int'(pc) + int'($signed(ctrl.imm));
        if (br_sum < 0) begin
            br_sum = br_sum + PROG_DEPTH;
        end else if (br_sum >= PROG_DEPTH) begin
            br_sum = br_sum - PROG_DEPTH;
        end
        target = PW'(br_sum);
    end

    assign redirect = ctrl.branch_en && (regs[0] != '0);

    // store port, data reg shares the rd field
    assign mem.we    = ctrl.mem_write;
    assign mem.addr  = regs[ctrl.addr_reg];
    assign mem.wdata = op_a;

    always_ff @(posedge clk) begin
        if (rst || launch) begin
            regs <= '{default: '0}; // fresh program starts from zero
        end else if (ctrl.write_en) begin
            regs[ctrl.rd] <= result;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid <= 1'b0;
            st_valid <= 1'b0;
        end else begin
            wb_valid <= ctrl.write_en; // one cycle strobe each
            st_valid <= ctrl.mem_write;
        end
    end

    always_ff @(posedge clk) begin
        wb_rec <= '{dest: ctrl.rd, data: result}; // payload only, no reset
        st_rec <= '{addr: mem.addr, data: mem.wdata};
    end

endmodule

//--- data_memory.sv
`timescale 1ns/1ns

module data_memory #(
    parameter int DATA_DEPTH = 256,
    localparam int DW = (DATA_DEPTH > 1) ? $clog2(DATA_DEPTH) : 1
) (
    input  logic            clk,
    input  logic            busy,       // core owns the memory
    input  logic            host_we,
    input  core_pkg::word_t host_addr,
    input  core_pkg::word_t host_wdata,
    output core_pkg::word_t host_data,
    mem_if.mem              mem
);

    logic            wr_en;  // muxed write strobe
    logic [DW-1:0]   wr_addr;
    core_pkg::word_t wr_data;
    logic [DW-1:0]   rd_addr;
    core_pkg::word_t rd_data;

    // core stores while busy, host writes while idle
    assign wr_en   = busy ? mem.we : host_we;
    assign wr_addr = busy ? mem.addr[DW-1:0] : host_addr[DW-1:0]; // low bits index
    assign wr_data = busy ? mem.wdata : host_wdata;
    assign rd_addr = busy ? mem.addr[DW-1:0] : host_addr[DW-1:0];

    ram_array #(
        .word_type (core_pkg::word_t),
        .DEPTH     (DATA_DEPTH)
    ) i_data_mem (
        .clk   (clk),
        .we    (wr_en),
        .waddr (wr_addr),
        .wdata (wr_data),
        .raddr (rd_addr),
        .rdata (rd_data)
    );

    assign mem.rdata = rd_data; // load data
    assign host_data = rd_data; // host readback when idle

endmodule

//--- tiny_core.sv
`timescale 1ns/1ns

module tiny_core #(
    parameter int PROG_DEPTH = 128,
    parameter int DATA_DEPTH = 256,
    localparam int PW = (PROG_DEPTH > 1) ? $clog2(PROG_DEPTH) : 1
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               prog_we,    // program load
    input  logic [PW-1:0]      prog_addr,
    input  isa_pkg::instr_t    prog_data,
    input  logic               start,
    output logic               busy,
    output logic               done_pulse,
    input  logic               host_we,    // data memory access
    input  core_pkg::word_t    host_addr,
    input  core_pkg::word_t    host_wdata,
    output core_pkg::word_t    host_data,
    output logic               wb_valid,   // register write trace
    output core_pkg::reg_idx_t wb_reg,
    output core_pkg::word_t    wb_data,
    output logic               st_valid,   // store trace
    output core_pkg::word_t    st_addr,
    output core_pkg::word_t    st_data
);

    logic              launch;
    logic              done;
    logic              redirect;
    logic [PW-1:0]     target;
    logic [PW-1:0]     pc;
    isa_pkg::instr_t   instr;
    core_pkg::wb_rec_t wb_rec;
    core_pkg::st_rec_t st_rec;

    ctrl_if i_ctrl_if ();
    mem_if  i_mem_if ();

    fetch_unit #(.PROG_DEPTH(PROG_DEPTH)) i_fetch_unit (
        .clk(clk), .rst(rst), .prog_we(prog_we), .prog_addr(prog_addr),
        .prog_data(prog_data), .start(start), .done(done), .redirect(redirect),
        .target(target), .launch(launch), .busy(busy), .done_pulse(done_pulse),
        .pc(pc), .instr(instr)
    );

    control_decoder i_control_decoder (
        .instr(instr), .valid(busy), .done(done), .ctrl(i_ctrl_if.dec)
    );

    execute_unit #(.PROG_DEPTH(PROG_DEPTH)) i_execute_unit (
        .clk(clk), .rst(rst), .launch(launch), .pc(pc),
        .ctrl(i_ctrl_if.exe), .mem(i_mem_if.exe), .redirect(redirect),
        .target(target), .wb_valid(wb_valid), .wb_rec(wb_rec),
        .st_valid(st_valid), .st_rec(st_rec)
    );

    data_memory #(.DATA_DEPTH(DATA_DEPTH)) i_data_memory (
        .clk(clk), .busy(busy), .host_we(host_we), .host_addr(host_addr),
        .host_wdata(host_wdata), .host_data(host_data), .mem(i_mem_if.mem)
    );

    // flatten trace records onto plain ports
    assign wb_reg  = wb_rec.dest;
    assign wb_data = wb_rec.data;
    assign st_addr = st_rec.addr;
    assign st_data = st_rec.data;

endmodule

//--- tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk; // 8 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk); // two cycles of reset
        rst <= 1'b0;
    end

endmodule

//--- tb_tiny_core.sv
`timescale 1ns/1ns

module tb_tiny_core;

    localparam int PROG_DEPTH = 128;
    localparam int N_PROGS    = 8;
    localparam int RUN_LIMIT  = 400; // cycles before a run counts as hung

    logic clk, rst, prog_we, start, host_we;
    logic [6:0] prog_addr;
    isa_pkg::instr_t prog_data;
    core_pkg::word_t host_addr, host_wdata, host_data, wb_data, st_addr, st_data;
    logic busy, done_pulse, wb_valid, st_valid;
    core_pkg::reg_idx_t wb_reg;

    logic [31:0]       lfsr;             // random source
    isa_pkg::instr_t   prog [PROG_DEPTH]; // current program
    int                prog_len;         // index of the done word
    core_pkg::word_t   model_mem [256];  // expected data memory
    core_pkg::wb_rec_t exp_wb [$];
    core_pkg::st_rec_t exp_st [$];
    int                exp_count;        // retired instructions incl. done

    tb_clock i_tb_clock (.clk(clk), .rst(rst));

    tiny_core #(.PROG_DEPTH(PROG_DEPTH), .DATA_DEPTH(256)) i_tiny_core (
        .clk(clk), .rst(rst), .prog_we(prog_we), .prog_addr(prog_addr),
        .prog_data(prog_data), .start(start), .busy(busy), .done_pulse(done_pulse),
        .host_we(host_we), .host_addr(host_addr), .host_wdata(host_wdata),
        .host_data(host_data), .wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data),
        .st_valid(st_valid), .st_addr(st_addr), .st_data(st_data)
    );

    // taps x^32 + x^22 + x^2 + x + 1 with one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        int          k;
        v = '0;
        for (k = 0; k < n; k++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_wb(input core_pkg::wb_rec_t got, input core_pkg::wb_rec_t exp);
        if (got !== exp) begin
            stop_run($sformatf("Error at %0t ns: write trace r%0d=%02h, expected r%0d=%02h",
                               $time, got.dest, got.data, exp.dest, exp.data));
        end
    endtask

    task automatic check_st(input core_pkg::st_rec_t got, input core_pkg::st_rec_t exp);
        if (got !== exp) begin
            stop_run($sformatf("Error at %0t ns: store trace [%02h]=%02h, expected [%02h]=%02h",
                               $time, got.addr, got.data, exp.addr, exp.data));
        end
    endtask

    task automatic check_word(input core_pkg::word_t got, input core_pkg::word_t exp,
                              input string what);
        if (got !== exp) begin
            stop_run($sformatf("Error at %0t ns: %s is %02h, expected %02h",
                               $time, what, got, exp));
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            stop_run($sformatf("Error at %0t ns: %s is %0d, expected %0d",
                               $time, what, got, exp));
        end
    endtask

    task automatic check_idle();
        check_count(int'(busy), 0, "busy while idle");
        check_count(int'(done_pulse), 0, "done_pulse while idle");
        check_count(int'(wb_valid), 0, "wb_valid while idle");
        check_count(int'(st_valid), 0, "st_valid while idle");
    endtask

    task automatic wait_reset();
        int n;
        n = 0;
        while (rst !== 1'b0) begin
            @(negedge clk);
            n++;
            if (n > 20) stop_run("reset was never released");
        end
    endtask

    task automatic load_data();
        int a;
        for (a = 0; a < 256; a++) begin
            @(negedge clk);
            check_idle();
            host_we       = 1'b1;
            host_addr     = 8'(a);
            host_wdata    = 8'(rand_bits(8));
            model_mem[a]  = host_wdata;
        end
        @(negedge clk);
        host_we = 1'b0;
    endtask

    task automatic readback_all();
        int a;
        for (a = 0; a < 256; a++) begin
            @(negedge clk);
            check_idle();
            host_addr = 8'(a);
            @(posedge clk); // host_data is combinational and settled by now
            check_word(host_data, model_mem[a], $sformatf("host read of %02h", a));
        end
    endtask

    // straight-line mix with forward branches only so every program ends
    task automatic gen_program();
        int i, kind, off;
        prog_len = 20 + int'(rand_bits(5)) % 21;
        for (i = 0; i < prog_len; i++) begin
            kind = int'(rand_bits(3));
            if (kind < 3) begin
                prog[i] = {2'b00, 7'(rand_bits(7))}; // alu op, rd, rs
            end else if (kind == 3) begin
                prog[i] = {2'b10, 7'(rand_bits(7))}; // immediate
            end else if (kind < 6) begin
                prog[i] = {2'b11, 7'(rand_bits(7))}; // load or store
            end else begin
                off = 1 + int'(rand_bits(4)) % 3;
                if (i + off > prog_len) off = prog_len - i; // stay inside
                prog[i] = {2'b01, 7'(off)};
            end
        end
        prog[prog_len] = 9'b010000000; // done
    endtask

    task automatic load_program();
        int i;
        for (i = 0; i <= prog_len; i++) begin
            @(negedge clk);
            check_idle();
            prog_we   = 1'b1;
            prog_addr = 7'(i);
            prog_data = prog[i];
        end
        @(negedge clk);
        prog_we = 1'b0;
    endtask

    // ISA reference with fresh registers for every program
    task automatic model_run();
        core_pkg::word_t   r [4];
        core_pkg::word_t   a, b, res;
        core_pkg::wb_rec_t wr;
        core_pkg::st_rec_t sr;
        isa_pkg::instr_t   w;
        int                pc;
        bit                fin;
        r = '{default: '0};
        pc = 0;
        fin = 1'b0;
        exp_count = 0;
        exp_wb.delete();
        exp_st.delete();
        while (!fin) begin
            w = prog[pc];
            exp_count++;
            if (exp_count > 1000) stop_run("reference model did not reach done");
            if (w == 9'b010000000) begin
                fin = 1'b1;
            end else if (w[8:7] == 2'b01) begin
                if (r[0] != 0) pc = (pc + int'($signed(w[6:0])) + PROG_DEPTH) % PROG_DEPTH;
                else pc = (pc + 1) % PROG_DEPTH;
            end else begin
                if (w[8:7] == 2'b00) begin
                    a = r[w[3:2]];
                    b = r[w[1:0]];
                    case (w[6:4])
                        3'd0: res = a & b;
                        3'd1: res = a + b;
                        3'd2: res = a - b;
                        3'd3: res = a | b;
                        3'd4: res = a ^ b;
                        3'd5: res = a << b[2:0];
                        3'd6: res = a >> b[2:0];
                        default: res = b; // move
                    endcase
                    wr = '{dest: w[3:2], data: res};
                end else if (w[8:7] == 2'b10) begin
                    res = r[0] + {w[6], w[6:0]};
                    wr = '{dest: 2'd1, data: res};
                end else if (w[6]) begin
                    sr = '{addr: r[w[3:2]], data: r[w[5:4]]};
                    model_mem[sr.addr] = sr.data;
                    exp_st.push_back(sr);
                end else begin
                    wr = '{dest: w[5:4], data: model_mem[r[w[3:2]]]};
                end
                if (!(w[8:7] == 2'b11 && w[6])) begin
                    r[wr.dest] = wr.data;
                    exp_wb.push_back(wr);
                end
                pc = (pc + 1) % PROG_DEPTH;
            end
        end
    endtask

    // start the core and follow the traces up to done_pulse with optional host traffic
    task automatic run_and_check(input bit disturb);
        int                cyc, busy_cycles, wb_idx, st_idx;
        bit                seen_done;
        core_pkg::word_t   poke_addr;
        core_pkg::wb_rec_t got_wb;
        core_pkg::st_rec_t got_st;
        cyc = 0;
        busy_cycles = 0;
        wb_idx = 0;
        st_idx = 0;
        seen_done = 1'b0;
        poke_addr = 8'(rand_bits(8));
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        while (!seen_done) begin
            start   = 1'b0;
            host_we = 1'b0;
            prog_we = 1'b0;
            if (busy) busy_cycles++;
            if (wb_valid) begin
                if (wb_idx >= exp_wb.size()) stop_run("more register writes than expected");
                got_wb = '{dest: wb_reg, data: wb_data};
                check_wb(got_wb, exp_wb[wb_idx]);
                wb_idx++;
            end
            if (st_valid) begin
                if (st_idx >= exp_st.size()) stop_run("more stores than expected");
                got_st = '{addr: st_addr, data: st_data};
                check_st(got_st, exp_st[st_idx]);
                st_idx++;
            end
            if (done_pulse) begin
                seen_done = 1'b1;
                check_count(int'(busy), 0, "busy with done_pulse");
                check_count(busy_cycles, exp_count, "busy cycles");
            end else if (disturb && cyc == 1 && busy) begin
                start      = 1'b1; // must be ignored
                host_we    = 1'b1;
                host_addr  = poke_addr;
                host_wdata = ~model_mem[poke_addr];
                prog_we    = 1'b1;
                prog_addr  = 7'(prog_len);
                prog_data  = '0; // would replace done
            end
            cyc++;
            if (cyc > RUN_LIMIT) stop_run("timed out waiting for done_pulse");
            @(negedge clk);
        end
        check_count(wb_idx, exp_wb.size(), "register write traces");
        check_count(st_idx, exp_st.size(), "store traces");
        check_count(int'(done_pulse), 0, "done_pulse second cycle");
    endtask

    initial begin
        prog_we    = 1'b0;
        prog_addr  = '0;
        prog_data  = '0;
        start      = 1'b0;
        host_we    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        lfsr       = 32'h1f6b6c70;
        wait_reset();
        load_data();
        readback_all();
        for (int p = 0; p < N_PROGS; p++) begin
            gen_program();
            load_program();
            model_run();
            run_and_check(p % 2 == 1); // every other run gets host traffic while busy
            readback_all();
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

//--- tiny_core.f
isa_pkg.sv
core_pkg.sv
ram_array.sv
core_if.sv
fetch_unit.sv
control_decoder.sv
execute_unit.sv
data_memory.sv
tiny_core.sv
tb_clock.sv
tb_tiny_core.sv

//--- Bender.yml
package:
  name: tiny_core

sources:
  - isa_pkg.sv
  - core_pkg.sv
  - ram_array.sv
  - core_if.sv
  - fetch_unit.sv
  - control_decoder.sv
  - execute_unit.sv
  - data_memory.sv
  - tiny_core.sv
  - target: simulation
    files:
      - tb_clock.sv
      - tb_tiny_core.sv
